/* include/glyph_rows.svh */
`ifndef GLYPH_ROWS_SVH
`define GLYPH_ROWS_SVH

// 8x8 character set, one 64 bit word per glyph
// top row sits in the most significant byte
// bit 7 of each byte is the leftmost pixel
// glyph order is 0..9 then A..Z then space = > comma ( )
function automatic logic [7:0] glyph_row(input int g, input int r);
  logic [63:0] bits;
  case (g)
    0:  bits = 64'h7cc6_cede_f6e6_7c00;  // 0
    1:  bits = 64'h3070_3030_3030_fc00;  // 1
    2:  bits = 64'h78cc_0c38_60cc_fc00;  // 2
    3:  bits = 64'h78cc_0c38_0ccc_7800;  // 3
    4:  bits = 64'h1c3c_6ccc_fe0c_1e00;  // 4
    5:  bits = 64'hfcc0_f80c_0ccc_7800;  // 5
    6:  bits = 64'h3860_c0f8_cccc_7800;  // 6
    7:  bits = 64'hfccc_0c18_3030_3000;  // 7
    8:  bits = 64'h78cc_cc78_cccc_7800;  // 8
    9:  bits = 64'h78cc_cc7c_0c18_7000;  // 9
    10: bits = 64'h3078_cccc_fccc_cc00;  // A
    11: bits = 64'hfc66_667c_6666_fc00;  // B
    12: bits = 64'h3c66_c0c0_c066_3c00;  // C
    13: bits = 64'hf86c_6666_666c_f800;  // D
    14: bits = 64'hfe62_6878_6862_fe00;  // E
    15: bits = 64'hfe62_6878_6860_f000;  // F
    16: bits = 64'h3c66_c0c0_ce66_3e00;  // G
    17: bits = 64'hcccc_ccfc_cccc_cc00;  // H
    18: bits = 64'h7830_3030_3030_7800;  // I
    19: bits = 64'h1e0c_0c0c_cccc_7800;  // J
    20: bits = 64'he666_6c78_6c66_e600;  // K
    21: bits = 64'hf060_6060_6266_fe00;  // L
    22: bits = 64'hc6ee_fefe_d6c6_c600;  // M
    23: bits = 64'hc6e6_f6de_cec6_c600;  // N
    24: bits = 64'h386c_c6c6_c66c_3800;  // O
    25: bits = 64'hfc66_667c_6060_f000;  // P
    26: bits = 64'h78cc_cccc_dc78_1c00;  // Q
    27: bits = 64'hfc66_667c_6c66_e600;  // R
    28: bits = 64'h78cc_e070_1ccc_7800;  // S
    29: bits = 64'hfcb4_3030_3030_7800;  // T
    30: bits = 64'hcccc_cccc_cccc_fc00;  // U
    31: bits = 64'hcccc_cccc_cc78_3000;  // V
    32: bits = 64'hc6c6_c6d6_feee_c600;  // W
    33: bits = 64'hc6c6_6c38_386c_c600;  // X
    34: bits = 64'hcccc_cc78_3030_7800;  // Y
    35: bits = 64'hfec6_8c18_3266_fe00;  // Z
    36: bits = 64'h0000_0000_0000_0000;  // space
    37: bits = 64'h0000_fc00_00fc_0000;  // =
    38: bits = 64'h6030_180c_1830_6000;  // >
    39: bits = 64'h0000_0000_0030_3060;  // comma
    40: bits = 64'h1830_6060_6030_1800;  // (
    41: bits = 64'h6030_1818_1830_6000;  // )
    default: bits = 64'h0;               // out of range draws nothing
  endcase
  return bits[8*(7-r) +: 8];             // row 0 is the top byte
endfunction

`endif

/* rtl/bmp_pkg.sv */
package bmp_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // screen and pixel geometry
  ////////////////////////////////////////////////////////////////////////////
  localparam int SCREEN_W     = 640;
  localparam int SCREEN_H     = 480;
  localparam int SCREEN_WORDS = SCREEN_W * SCREEN_H;  // 307200 frame words
  localparam int VADDR_W      = 19;                   // enough for SCREEN_WORDS
  localparam int PIX_W        = 6;                    // 2 bits each of r, g and b

  localparam logic [PIX_W-1:0] TRANSPARENT = 6'h24;   // never written to the frame
  localparam logic [PIX_W-1:0] FONT_FG     = 6'h3f;   // white glyph pixels

  ////////////////////////////////////////////////////////////////////////////
  // image and font rom layout
  ////////////////////////////////////////////////////////////////////////////
  localparam int NUM_IMAGES  = 4;
  localparam int IMG_REGION  = 1024;  // words per image slot
  localparam int IMG_ADDR_W  = 12;    // NUM_IMAGES * IMG_REGION words
  localparam int HDR_WORDS   = 4;     // width hi/lo then height hi/lo, base 64 digits

  localparam int NUM_GLYPHS  = 42;
  localparam int GLYPH_SIZE  = 8;     // glyphs are square
  localparam int FONT_ADDR_W = 12;    // 42 glyphs of 64 words

  // command opcodes
  typedef enum logic [1:0] {
    OP_ADD_IMG = 2'd0,  // copy bitmap, skip transparent words
    OP_REM_IMG = 2'd1,  // black out the opaque footprint of a bitmap
    OP_ADD_FNT = 2'd2   // draw one glyph in FONT_FG
  } blit_op_e;

  // one blit request, 27 bits
  typedef struct packed {
    blit_op_e   op;
    logic [5:0] index;  // image 0..3 or glyph 0..41
    logic [9:0] xloc;   // left column
    logic [8:0] yloc;   // top row
  } blit_cmd_t;

  // write port bundle into the frame buffer, 26 bits
  typedef struct packed {
    logic               we;
    logic [VADDR_W-1:0] addr;
    logic [PIX_W-1:0]   data;
  } vid_wr_t;

  typedef struct packed {
    logic [1:0] r;
    logic [1:0] g;
    logic [1:0] b;
  } pix_t;

  // a rom word is a header digit or a colour depending on where it sits
  typedef union packed {
    logic [PIX_W-1:0] dim;  // header view, one base 64 digit
    pix_t             pix;  // pixel view
  } rom_word_u;

endpackage

/* rtl/image_rom.sv */
`timescale 1ns/1ps

module image_rom (
  input  logic                            clk,
  input  logic [bmp_pkg::IMG_ADDR_W-1:0]  addr,
  output bmp_pkg::rom_word_u              dout
);
  import bmp_pkg::*;

  logic [PIX_W-1:0] mem [NUM_IMAGES*IMG_REGION];

  // image k is (8+4k) wide and (6+2k) tall
  function automatic int img_width(input int k);
    return 8 + 4*k;
  endfunction

  function automatic int img_height(input int k);
    return 6 + 2*k;
  endfunction

  // header plus pixels, the part of a slot that holds data
  function automatic int img_words(input int k);
    return HDR_WORDS + img_width(k) * img_height(k);
  endfunction

  function automatic logic [PIX_W-1:0] img_pixel(input int k, input int x, input int y);
    logic [PIX_W-1:0] v;
    v = PIX_W'(16*k + x + 3*y);            // truncation gives mod 64
    if (x == y) return TRANSPARENT;        // see-through diagonal
    if (v == TRANSPARENT) return 6'h25;    // keep opaque pixels off the key
    return v;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // build all four bitmaps at start
  ////////////////////////////////////////////////////////////////////////////
  initial begin
    int base;
    int w;
    int h;
    foreach (mem[i]) mem[i] = '0;          // unused tail of each slot
    for (int k = 0; k < NUM_IMAGES; k++) begin
      base = k * IMG_REGION;
      w    = img_width(k);
      h    = img_height(k);
      mem[base]     = PIX_W'(w / 64);      // width hi digit
      mem[base + 1] = PIX_W'(w % 64);
      mem[base + 2] = PIX_W'(h / 64);      // height hi digit
      mem[base + 3] = PIX_W'(h % 64);
      for (int y = 0; y < h; y++)
        for (int x = 0; x < w; x++)
          mem[base + HDR_WORDS + y*w + x] = img_pixel(k, x, y);  // row major
    end
  end

  always_ff @(posedge clk)
    dout.dim <= mem[addr];                 // one cycle read latency

  // the placer never runs past the end of a bitmap
  a_in_slot: assert property (@(posedge clk)
    int'(addr % IMG_REGION) < img_words(int'(addr / IMG_REGION)));

endmodule

/* rtl/font_rom.sv */
`timescale 1ns/1ps

module font_rom (
  input  logic                             clk,
  input  logic [bmp_pkg::FONT_ADDR_W-1:0]  addr,
  output bmp_pkg::rom_word_u               dout
);
  import bmp_pkg::*;

  `include "glyph_rows.svh"

  // 64 words per glyph, row major, glyph g starts at g*64
  logic [PIX_W-1:0] mem [NUM_GLYPHS*GLYPH_SIZE*GLYPH_SIZE];

  ////////////////////////////////////////////////////////////////////////////
  // expand the bit table into pixel words
  ////////////////////////////////////////////////////////////////////////////
  initial begin
    logic [7:0] bits;
    for (int g = 0; g < NUM_GLYPHS; g++) begin
      for (int r = 0; r < GLYPH_SIZE; r++) begin
        bits = glyph_row(g, r);
        for (int c = 0; c < GLYPH_SIZE; c++)
          mem[(g*GLYPH_SIZE + r)*GLYPH_SIZE + c] =
            bits[7-c] ? FONT_FG : TRANSPARENT;  // set bit means ink
      end
    end
  end

  always_ff @(posedge clk)
    dout.dim <= mem[addr];  // registered read like the image rom

endmodule

/* rtl/bmp_placer.sv */
`timescale 1ns/1ps

module bmp_placer (
  input  logic                             clk,
  input  logic                             rst_n,
  input  logic                             cmd_go,     // one cycle strobe
  input  bmp_pkg::blit_cmd_t               cmd,
  input  bmp_pkg::rom_word_u               img_word,   // image rom data one cycle late
  input  bmp_pkg::rom_word_u               font_word,  // font rom data one cycle late
  output logic [bmp_pkg::IMG_ADDR_W-1:0]   img_addr,
  output logic [bmp_pkg::FONT_ADDR_W-1:0]  font_addr,
  output bmp_pkg::vid_wr_t                 wr,
  output logic                             busy         // low only in IDLE
);
  import bmp_pkg::*;

  typedef enum logic [3:0] {
    IDLE, PRIME, HDR_XH, HDR_XL, HDR_YH, HDR_YL, IMG_WR, FNT_PRIME, FNT_WR
  } state_e;

  state_e state, nxt_state;

  logic               rem;          // remove op writes black
  logic [9:0]         img_w;        // bitmap width from header
  logic [8:0]         img_h;        // bitmap height from header
  logic [9:0]         col;          // column inside bitmap or glyph
  logic [8:0]         row;
  logic [VADDR_W-1:0] waddr;        // frame address of current pixel

  logic               accept;
  logic               img_row_end;
  logic               img_last;
  logic               img_hold;     // stop rom address at last pixel
  logic               fnt_row_end;
  logic               fnt_last;
  logic               fnt_hold;
  logic [PIX_W-1:0]   img_rgb;
  logic [PIX_W-1:0]   fnt_rgb;

  assign accept = cmd_go && (state == IDLE);  // strobes while busy are dropped
  assign busy   = (state != IDLE);

  // end of row and end of shape flags
  assign img_row_end = (col == img_w - 10'd1);
  assign img_last    = img_row_end && (row == img_h - 9'd1);
  assign img_hold    = (row == img_h - 9'd1) && (col >= img_w - 10'd2);
  assign fnt_row_end = (col == 10'(GLYPH_SIZE - 1));
  assign fnt_last    = fnt_row_end && (row == 9'(GLYPH_SIZE - 1));
  assign fnt_hold    = fnt_row_end ||
                       ((row == 9'(GLYPH_SIZE - 1)) && (col == 10'(GLYPH_SIZE - 2)));

  // colours through the pixel view
  assign img_rgb = {img_word.pix.r, img_word.pix.g, img_word.pix.b};
  assign fnt_rgb = {font_word.pix.r, font_word.pix.g, font_word.pix.b};

  ////////////////////////////////////////////////////////////////////////////
  // next state
  ////////////////////////////////////////////////////////////////////////////
  always_comb begin
    nxt_state = state;
    case (state)
      IDLE: begin
        if (cmd_go) begin
          case (cmd.op)
            OP_ADD_IMG, OP_REM_IMG: nxt_state = PRIME;
            OP_ADD_FNT:             nxt_state = FNT_PRIME;
            default:                nxt_state = IDLE;  // unused opcode
          endcase
        end
      end
      PRIME:     nxt_state = HDR_XH;     // rom now holds width hi
      HDR_XH:    nxt_state = HDR_XL;
      HDR_XL:    nxt_state = HDR_YH;
      HDR_YH:    nxt_state = HDR_YL;
      HDR_YL:    nxt_state = IMG_WR;     // first pixel arrives next
      IMG_WR:    if (img_last) nxt_state = IDLE;
      FNT_PRIME: nxt_state = FNT_WR;
      FNT_WR: begin
        if (fnt_row_end)
          nxt_state = fnt_last ? IDLE : FNT_PRIME;  // prime again per glyph row
      end
      default:   nxt_state = IDLE;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // state, counters and addresses
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= IDLE;
      col       <= '0;
      row       <= '0;
      img_addr  <= '0;
      font_addr <= '0;
      waddr     <= '0;
    end else begin
      state <= nxt_state;
      case (state)
        IDLE: begin
          if (accept) begin
            col   <= '0;
            row   <= '0;
            waddr <= VADDR_W'(cmd.yloc) * VADDR_W'(SCREEN_W) + VADDR_W'(cmd.xloc);
            if (cmd.op == OP_ADD_FNT)
              font_addr <= FONT_ADDR_W'(cmd.index) * FONT_ADDR_W'(GLYPH_SIZE*GLYPH_SIZE);
            else
              img_addr <= IMG_ADDR_W'(cmd.index) * IMG_ADDR_W'(IMG_REGION);
          end
        end
        PRIME, HDR_XH, HDR_XL, HDR_YH, HDR_YL:
          img_addr <= img_addr + 1'b1;       // walk through the header
        IMG_WR: begin
          if (!img_hold)
            img_addr <= img_addr + 1'b1;
          if (img_row_end) begin
            col   <= '0;
            row   <= row + 9'd1;
            waddr <= waddr + VADDR_W'(SCREEN_W + 1) - VADDR_W'(img_w);  // next screen line
          end else begin
            col   <= col + 10'd1;
            waddr <= waddr + 1'b1;
          end
        end
        FNT_PRIME:
          font_addr <= font_addr + 1'b1;
        FNT_WR: begin
          if (!fnt_hold)
            font_addr <= font_addr + 1'b1;   // parks on next row start
          if (fnt_row_end) begin
            col   <= '0;
            row   <= row + 9'd1;
            waddr <= waddr + VADDR_W'(SCREEN_W - GLYPH_SIZE + 1);
          end else begin
            col   <= col + 10'd1;
            waddr <= waddr + 1'b1;
          end
        end
        default: ;
      endcase
    end
  end

  // command flag and header digits
  always_ff @(posedge clk) begin
    if (accept)
      rem <= (cmd.op == OP_REM_IMG);
    case (state)
      HDR_XH:  img_w      <= {img_word.dim[3:0], 6'd0};  // hi digit times 64
      HDR_XL:  img_w[5:0] <= img_word.dim;
      HDR_YH:  img_h      <= {img_word.dim[2:0], 6'd0};
      HDR_YL:  img_h[5:0] <= img_word.dim;
      default: ;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // write port to the frame buffer
  ////////////////////////////////////////////////////////////////////////////
  always_comb begin
    wr.we   = 1'b0;
    wr.addr = waddr;
    wr.data = '0;
    case (state)
      IMG_WR: begin
        wr.we   = (img_rgb != TRANSPARENT);  // key colour is skipped
        wr.data = rem ? '0 : img_rgb;        // remove paints black
      end
      FNT_WR: begin
        wr.we   = (fnt_rgb != TRANSPARENT);
        wr.data = fnt_rgb;
      end
      default: ;
    endcase
  end

  a_waddr_range: assert property (@(posedge clk) disable iff (!rst_n)
    wr.we |-> (wr.addr < SCREEN_WORDS));

  // glyph index checked against the font and image index against the slots
  a_index_range: assert property (@(posedge clk) disable iff (!rst_n)
    accept |-> ((cmd.op == OP_ADD_FNT) ? (cmd.index < NUM_GLYPHS)
                                       : (cmd.index < NUM_IMAGES)));

endmodule

/* rtl/video_mem.sv */
`timescale 1ns/1ps

module video_mem (
  input  logic                          clk,
  input  bmp_pkg::vid_wr_t              wr,
  input  logic [bmp_pkg::VADDR_W-1:0]   rd_addr,
  output logic [bmp_pkg::PIX_W-1:0]     rd_data
);
  import bmp_pkg::*;

  logic [PIX_W-1:0] mem [SCREEN_WORDS];  // one word per pixel, row major

  initial begin
    foreach (mem[i]) mem[i] = '0;        // screen starts black
  end

  ////////////////////////////////////////////////////////////////////////////
  // write port from the placer
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (wr.we)
      mem[wr.addr] <= wr.data;
  end

  ////////////////////////////////////////////////////////////////////////////
  // display side read, one cycle latency
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk)
    rd_data <= mem[rd_addr];             // old data on a same cycle write

  a_rd_range: assert property (@(posedge clk)
    rd_addr < SCREEN_WORDS);

endmodule

/* rtl/sprite_blit_top.sv */
`timescale 1ns/1ps

module sprite_blit_top (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          cmd_go,   // taken only while busy is low
  input  bmp_pkg::blit_cmd_t            cmd,
  input  logic [bmp_pkg::VADDR_W-1:0]   rd_addr,  // display read address
  output logic                          busy,
  output logic [bmp_pkg::PIX_W-1:0]     rd_data
);
  import bmp_pkg::*;

  logic [IMG_ADDR_W-1:0]  img_addr;
  logic [FONT_ADDR_W-1:0] font_addr;
  rom_word_u              img_word;   // bitmap header or pixel
  rom_word_u              font_word;  // glyph pixel
  vid_wr_t                wr;         // placer to frame buffer

  ////////////////////////////////////////////////////////////////////////////
  // command engine
  ////////////////////////////////////////////////////////////////////////////
  bmp_placer placer0 (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_go    (cmd_go),
    .cmd       (cmd),
    .img_word  (img_word),
    .font_word (font_word),
    .img_addr  (img_addr),
    .font_addr (font_addr),
    .wr        (wr),
    .busy      (busy)
  );

  // source roms
  image_rom img_rom0 (.clk(clk), .addr(img_addr),  .dout(img_word));
  font_rom  fnt_rom0 (.clk(clk), .addr(font_addr), .dout(font_word));

  ////////////////////////////////////////////////////////////////////////////
  // frame buffer
  ////////////////////////////////////////////////////////////////////////////
  video_mem vmem0 (
    .clk     (clk),
    .wr      (wr),
    .rd_addr (rd_addr),
    .rd_data (rd_data)
  );

endmodule

/* verification/tb_sprite_blit.sv */
`timescale 1ns/1ps

module tb_sprite_blit;
  import bmp_pkg::*;

  `undef GLYPH_ROWS_SVH     // guard already set where the font rom pulled it in
  `include "glyph_rows.svh"

  localparam int CMD_BUDGET   = 700;  // cycles per command incl. readback
  localparam int RESET_BUDGET = 64;
  localparam int NUM_CMDS     = 17;   // every cmd_go pulse of the run
  localparam int WATCHDOG_NS  = 2 * (RESET_BUDGET + NUM_CMDS * CMD_BUDGET) * 10;

  logic               clk;
  logic               rst_n;
  logic               cmd_go;
  blit_cmd_t          cmd;
  logic [VADDR_W-1:0] rd_addr;
  logic               busy;
  logic [PIX_W-1:0]   rd_data;

  logic [PIX_W-1:0] ref_mem [SCREEN_WORDS];  // expected frame contents
  logic [31:0]      rng_state;
  int               busy_falls;              // seen on the busy pin
  int               accepted;                // commands the tb expects taken

  sprite_blit_top dut0 (
    .clk     (clk),
    .rst_n   (rst_n),
    .cmd_go  (cmd_go),
    .cmd     (cmd),
    .rd_addr (rd_addr),
    .busy    (busy),
    .rd_data (rd_data)
  );

  initial clk = 1'b0;
  always #5 clk = ~clk;  // 10 ns period

  always @(negedge busy)
    if (rst_n) busy_falls++;  // X to 0 during reset is not a completion

  ////////////////////////////////////////////////////////////////////////////
  // reference rules
  ////////////////////////////////////////////////////////////////////////////
  function automatic logic [31:0] next_rand();
    rng_state ^= rng_state << 13;
    rng_state ^= rng_state >> 17;
    rng_state ^= rng_state << 5;
    return rng_state;
  endfunction

  function automatic int image_width(input int k);
    return 8 + 4*k;
  endfunction

  function automatic int image_height(input int k);
    return 6 + 2*k;
  endfunction

  function automatic logic [PIX_W-1:0] image_pixel(input int k, input int x, input int y);
    int v;
    if (x == y) return TRANSPARENT;          // diagonal is see-through
    v = (16*k + x + 3*y) % 64;
    if (v == int'(TRANSPARENT)) return 6'h25;
    return PIX_W'(v);
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // drive and check helpers
  ////////////////////////////////////////////////////////////////////////////
  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("mismatch at %0t ns: %s got %0h expected %0h", $time, name, got, exp);
      $display("Finished with errors");
      $fatal(1, "stopped at first wrong value");
    end
  endtask

  task automatic issue_cmd(input blit_op_e op, input int index, input int x, input int y);
    @(negedge clk);
    cmd.op    = op;
    cmd.index = 6'(index);
    cmd.xloc  = 10'(x);
    cmd.yloc  = 9'(y);
    cmd_go    = 1'b1;
    @(negedge clk);
    cmd_go    = 1'b0;                        // single cycle strobe
  endtask

  task automatic wait_idle();
    int n;
    n = 0;
    while (busy) begin
      @(negedge clk);
      n++;
      if (n > CMD_BUDGET) begin
        $display("busy stayed high for more than %0d cycles", CMD_BUDGET);
        $display("Finished with errors");
        $fatal(1, "command never completed");
      end
    end
  endtask

  task automatic run_cmd(input blit_op_e op, input int index, input int x, input int y);
    issue_cmd(op, index, x, y);
    check("busy", busy, 1);                  // rose on the acceptance edge
    wait_idle();
    accepted++;
  endtask

  // entered on a falling edge and data is back one edge later
  task automatic read_expect(input int a, input logic [PIX_W-1:0] exp);
    rd_addr = VADDR_W'(a);
    @(negedge clk);
    check($sformatf("rd_data at %0d", a), rd_data, exp);
  endtask

  task automatic read_rect(input int x0, input int y0, input int w, input int h);
    for (int r = 0; r < h; r++)
      for (int c = 0; c < w; c++)
        read_expect((y0 + r)*SCREEN_W + x0 + c, ref_mem[(y0 + r)*SCREEN_W + x0 + c]);
  endtask

  task automatic update_image_ref(input blit_op_e op, input int k, input int x, input int y);
    logic [PIX_W-1:0] p;
    for (int r = 0; r < image_height(k); r++)
      for (int c = 0; c < image_width(k); c++) begin
        p = image_pixel(k, c, r);
        if (p != TRANSPARENT)
          ref_mem[(y + r)*SCREEN_W + x + c] = (op == OP_REM_IMG) ? 6'h00 : p;
      end
  endtask

  task automatic draw_image(input blit_op_e op, input int k, input int x, input int y);
    run_cmd(op, k, x, y);
    update_image_ref(op, k, x, y);
    read_rect(x - 1, y - 1, image_width(k) + 2, image_height(k) + 2);  // with border
  endtask

  task automatic draw_glyph(input int g, input int x, input int y);
    logic [7:0] bits;
    run_cmd(OP_ADD_FNT, g, x, y);
    for (int r = 0; r < GLYPH_SIZE; r++) begin
      bits = glyph_row(g, r);
      for (int c = 0; c < GLYPH_SIZE; c++)
        if (bits[7-c]) ref_mem[(y + r)*SCREEN_W + x + c] = FONT_FG;
    end
    read_rect(x - 1, y - 1, GLYPH_SIZE + 2, GLYPH_SIZE + 2);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // directed tests
  ////////////////////////////////////////////////////////////////////////////
  task automatic check_reset_state();
    check("busy", busy, 0);
    repeat (16) read_expect(int'(next_rand() % SCREEN_WORDS), 6'h00);  // frame starts black
  endtask

  task automatic place_all_images();
    for (int k = 0; k < NUM_IMAGES; k++)
      draw_image(OP_ADD_IMG, k, 40 + 120*k, 30);
  endtask

  task automatic overlap_images();
    draw_image(OP_ADD_IMG, 2, 300, 200);
    draw_image(OP_ADD_IMG, 1, 302, 201);     // offset (2,1) over image 2
    read_expect(202*SCREEN_W + 303, image_pixel(2, 3, 2));  // diagonal shows image 2
  endtask

  task automatic remove_image_overlap();
    draw_image(OP_ADD_IMG, 3, 500, 300);
    draw_image(OP_ADD_IMG, 0, 503, 302);
    draw_image(OP_REM_IMG, 0, 503, 302);
    read_expect(303*SCREEN_W + 504, image_pixel(3, 4, 3));  // under the diagonal
    read_expect(302*SCREEN_W + 504, 6'h00);                 // opaque so now black
  endtask

  task automatic draw_glyphs();
    int g;
    int x;
    int y;
    repeat (6) begin
      g = int'(next_rand() % 32'd42);
      x = 8 + int'(next_rand() % 32'd600);   // keeps glyph and border on screen
      y = 8 + int'(next_rand() % 32'd440);
      draw_glyph(g, x, y);
    end
  endtask

  task automatic ignore_go_while_busy();
    int falls_before;
    falls_before = busy_falls;
    issue_cmd(OP_ADD_IMG, 3, 100, 400);
    check("busy", busy, 1);
    repeat (5) @(negedge clk);
    issue_cmd(OP_ADD_FNT, 10, 200, 400);     // offered mid blit and must be dropped
    check("busy", busy, 1);
    wait_idle();
    accepted++;
    update_image_ref(OP_ADD_IMG, 3, 100, 400);
    repeat (4) @(negedge clk);
    check("busy", busy, 0);                  // nothing was queued
    read_rect(99, 399, image_width(3) + 2, image_height(3) + 2);
    read_rect(199, 399, GLYPH_SIZE + 2, GLYPH_SIZE + 2);  // glyph area untouched
    check("busy falls", busy_falls - falls_before, 1);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // main sequence and watchdog
  ////////////////////////////////////////////////////////////////////////////
  initial begin
    rst_n      = 1'b0;
    cmd_go     = 1'b0;
    cmd        = '0;
    rd_addr    = '0;
    rng_state  = 32'he2ea_557b;
    busy_falls = 0;
    accepted   = 0;
    foreach (ref_mem[i]) ref_mem[i] = '0;
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    check_reset_state();
    place_all_images();
    overlap_images();
    remove_image_overlap();
    draw_glyphs();
    ignore_go_while_busy();
    check("busy falls", busy_falls, accepted);  // one fall per accepted command

    $display("Finished with no errors");
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("timeout, the run did not finish within %0d ns", WATCHDOG_NS);
    $display("Finished with errors");
    $fatal(1, "watchdog expired");
  end

endmodule

/* sim.f */
+incdir+include
rtl/bmp_pkg.sv
rtl/image_rom.sv
rtl/font_rom.sv
rtl/bmp_placer.sv
rtl/video_mem.sv
rtl/sprite_blit_top.sv
verification/tb_sprite_blit.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the sprite blitter testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f sim.f \
  --top-module tb_sprite_blit --Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/Vtb_sprite_blit > sim.log 2>&1
run_status=$?
cat sim.log

# the log decides, a nonzero exit from the model also counts as failure
if grep -q "Finished with no errors" sim.log && [ "$run_status" -eq 0 ]; then
  echo "simulation passed"
  exit 0
fi
echo "simulation failed, see sim.log"
exit 1
